// File: testbench/mem_subsystem_stimulus.txt
# op R count | S res_ord addr data count | L addr expected count
# op C res_ord count | F flush | D wait for drain | addr and data in hex
L 0010 0000 1
R 1
S 0 0010 1234 1
L 0010 1234 1
C 0 1
L 0010 1234 1
D
L 0010 1234 2
R 2
S 1 0020 aaaa 1
S 2 0020 bbbb 1
L 0020 bbbb 1
C 1 2
L 0020 bbbb 4
D
L 0020 bbbb 1
R 2
S 3 0030 1111 1
S 4 0030 2222 1
C 3 1
L 0030 2222 1
F
L 0030 1111 1
R 1
S 5 0040 5555 1
F
L 0040 0000 1
D
L 0030 1111 1
R 32
S 6 0080 c000 32
L 0085 c005 1
C 6 32
L 008a c00a 3
D
L 009f c01f 1
L 0030 1111 1

// File: mem_subsystem.f
+incdir+hw
hw/mem_subsystem_pkg.sv
hw/load_store_unit.sv
hw/store_buffer.sv
hw/data_memory.sv
hw/mem_subsystem.sv
testbench/mem_subsystem_assertions.sv
testbench/tb_mem_subsystem.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the memory subsystem testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_mem_subsystem \
	-f mem_subsystem.f -o tb_mem_subsystem \
	&& ./obj_dir/tb_mem_subsystem | tee /dev/stderr | grep -q "TEST OK" \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }

// File: testbench/tb_mem_subsystem.sv
`default_nettype none
`timescale 1ns/1ps

`include "mem_subsystem_config.svh"

module tb_mem_subsystem;
	import mem_subsystem_pkg::*;

	localparam int TIMEOUT = 200;  // Cycles allowed per wait

	// Reference entry of the store buffer
	typedef struct packed {
		int      ord;        // Reserve order in the stimulus file
		sb_idx_t slot;
		addr_t   addr;
		data_t   data;
		logic    filled;
		logic    committed;
	} sb_entry_t;

	logic clk;
	logic rst_n;
	logic reserve;
	logic issue_valid;
	logic retire_valid;
	logic flush;
	ls_issue_t issue;
	sb_idx_t retire_index;
	sb_idx_t reserve_index;
	logic sb_full;
	logic sb_empty;
	logic load_done;
	data_t load_data;

	sb_entry_t sbq[$];        // Buffer model, oldest first
	data_t want_q[$];         // Expected results of loads in flight
	data_t mem_model [1 << `MEM_ADDR_BITS];
	sb_idx_t model_tail;
	sb_idx_t next_commit;     // One past the last committed slot
	int next_ord;
	int errors;
	int aborts;

	mem_subsystem uut (
		.clk(clk), .rst_n(rst_n),
		.reserve(reserve), .reserve_index(reserve_index),
		.sb_full(sb_full), .sb_empty(sb_empty),
		.issue_valid(issue_valid), .issue(issue),
		.retire_valid(retire_valid), .retire_index(retire_index), .flush(flush),
		.load_done(load_done), .load_data(load_data)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// ------------------------------
	// Helpers
	task automatic report_and_finish();
		$display("Closing summary: %0d value errors, %0d aborted runs", errors, aborts);
		if (errors == 0 && aborts == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	endtask

	task automatic record_failure(input string why);
		aborts++;
		$display("%s", why);
	endtask

	task automatic check_value(input logic [31:0] got, input logic [31:0] want,
			input string what);
		if (got !== want) begin
			errors++;
			$display("** Error at %0t: %s, got %h, expected %h", $time, what, got, want);
		end
	endtask

	task automatic next_cycle();
		@(posedge clk);
		#1;  // Drive point after the edge
	endtask

	function automatic int find_entry(input int ord);
		foreach (sbq[i]) begin
			if (sbq[i].ord == ord) return i;
		end
		return -1;
	endfunction

	// Newest filled store wins, else the memory word
	function automatic data_t model_load(input addr_t a);
		for (int i = sbq.size() - 1; i >= 0; i--) begin
			if (sbq[i].filled && sbq[i].addr == a) return sbq[i].data;
		end
		return mem_model[a[`MEM_ADDR_BITS-1:0]];
	endfunction

	// ------------------------------
	// Operations
	task automatic reserve_slots(input int n);
		sb_entry_t e;
		logic any_committed;
		for (int i = 0; i < n; i++) begin
			check_value(32'(reserve_index), 32'(model_tail), "reserve_index");
			e = '{ord: next_ord, slot: model_tail, addr: '0, data: '0,
				filled: 1'b0, committed: 1'b0};
			sbq.push_back(e);
			next_ord++;
			model_tail = model_tail + sb_idx_t'(1);
			reserve = 1'b1;
			next_cycle();
		end
		reserve = 1'b0;
		any_committed = 1'b0;
		foreach (sbq[i]) any_committed |= sbq[i].committed;
		if (n > 0) begin
			check_value(32'(sb_empty), 32'd0, "sb_empty with reserved slots");
		end
		if (sbq.size() < `SB_DEPTH) begin
			check_value(32'(sb_full), 32'd0, "sb_full below depth");
		end else if (!any_committed) begin
			check_value(32'(sb_full), 32'd1, "sb_full at depth");
		end
	endtask

	task automatic fill_slots(input int k, input addr_t a, input data_t d, input int n);
		int pos;
		sb_entry_t e;
		for (int i = 0; i < n; i++) begin
			pos = find_entry(k + i);
			if (pos < 0) begin
				record_failure("Stimulus stores to a slot that was never reserved");
				break;
			end
			e = sbq[pos];
			e.addr = a + addr_t'(i);
			e.data = d + data_t'(i);
			e.filled = 1'b1;
			sbq[pos] = e;
			issue = '{is_store: 1'b1, base: e.addr - 16'h0004, offset: 16'h0004,
				src_data: e.data, sb_index: e.slot};
			issue_valid = 1'b1;
			next_cycle();
		end
		issue_valid = 1'b0;
	endtask

	task automatic issue_loads(input addr_t a, input data_t file_want, input int n);
		data_t want;
		addr_t off;
		int waited;
		want = model_load(a);
		check_value(32'(want), 32'(file_want), "stimulus file expected data");
		for (int i = 0; i < n; i++) begin
			off = addr_t'(i + 1);
			issue = '{is_store: 1'b0, base: a - off, offset: off, src_data: '0, sb_index: '0};
			issue_valid = 1'b1;
			want_q.push_back(want);
			next_cycle();
		end
		issue_valid = 1'b0;
		waited = 0;
		while (want_q.size() != 0 && waited < TIMEOUT) begin
			next_cycle();
			waited++;
		end
		if (want_q.size() != 0) record_failure("Timeout waiting for load results");
	endtask

	task automatic commit_slots(input int k, input int n);
		int pos;
		sb_entry_t e;
		for (int i = 0; i < n; i++) begin
			pos = find_entry(k + i);
			if (pos < 0) begin
				record_failure("Stimulus commits a slot that was never reserved");
				break;
			end
			e = sbq[pos];
			e.committed = 1'b1;
			sbq[pos] = e;
			next_commit = e.slot + sb_idx_t'(1);
			retire_index = e.slot;
			retire_valid = 1'b1;
			next_cycle();
		end
		retire_valid = 1'b0;
	endtask

	task automatic flush_buffer();
		flush = 1'b1;
		next_cycle();
		flush = 1'b0;
		while (sbq.size() != 0 && !sbq[sbq.size() - 1].committed) begin
			void'(sbq.pop_back());  // Speculative stores are the newest
		end
		model_tail = next_commit;
	endtask

	task automatic wait_drain();
		int waited;
		waited = 0;
		while (!sb_empty && waited < TIMEOUT) begin
			next_cycle();
			waited++;
		end
		if (!sb_empty) begin
			record_failure("Timeout waiting for the store buffer to drain");
		end else begin
			foreach (sbq[i]) mem_model[sbq[i].addr[`MEM_ADDR_BITS-1:0]] = sbq[i].data;
			sbq.delete();
			check_value(32'(sb_full), 32'd0, "sb_full after drain");
		end
	endtask

	// ------------------------------
	// Load result monitor, sampled mid-cycle
	initial begin
		forever begin
			@(negedge clk);
			if (rst_n && load_done) begin
				if (want_q.size() == 0) begin
					errors++;
					$display("A load result appeared at %0t with no load outstanding", $time);
				end else begin
					check_value(32'(load_data), 32'(want_q.pop_front()), "load_data");
				end
			end
		end
	end

	initial begin
		repeat (20000) @(posedge clk);
		record_failure("Simulation watchdog expired before the stimulus ended");
		report_and_finish();
	end

	initial begin
		int fd;
		int code;
		int k;
		int n;
		string op;
		string rest;
		addr_t a;
		data_t d;
		void'($urandom(3));
		{reserve, issue_valid, retire_valid, flush} = '0;
		issue = '0;
		retire_index = '0;
		rst_n = 1'b0;
		model_tail = '0;
		next_commit = '0;
		next_ord = 0;
		errors = 0;
		aborts = 0;
		foreach (mem_model[i]) mem_model[i] = '0;
		fd = $fopen("testbench/mem_subsystem_stimulus.txt", "r");
		if (fd == 0) record_failure("Cannot open the stimulus file");
		repeat (8) @(posedge clk);
		#1 rst_n = 1'b1;
		check_value(32'(sb_empty), 32'd1, "sb_empty after reset");
		check_value(32'(reserve_index), 32'd0, "reserve_index after reset");

		while (fd != 0 && aborts == 0) begin
			if ($fscanf(fd, "%s", op) != 1) break;
			case (op)
				"#": code = $fgets(rest, fd);
				"R": begin
					code = $fscanf(fd, "%d", n);
					if (code == 1) reserve_slots(n);
					else record_failure("Malformed R line in the stimulus file");
				end
				"S": begin
					code = $fscanf(fd, "%d %h %h %d", k, a, d, n);
					if (code == 4) fill_slots(k, a, d, n);
					else record_failure("Malformed S line in the stimulus file");
				end
				"L": begin
					code = $fscanf(fd, "%h %h %d", a, d, n);
					if (code == 3) issue_loads(a, d, n);
					else record_failure("Malformed L line in the stimulus file");
				end
				"C": begin
					code = $fscanf(fd, "%d %d", k, n);
					if (code == 2) commit_slots(k, n);
					else record_failure("Malformed C line in the stimulus file");
				end
				"F": flush_buffer();
				"D": wait_drain();
				default: record_failure({"Unknown opcode in the stimulus file: ", op});
			endcase
			repeat ($urandom % 4) next_cycle();  // Idle gap
		end
		if (fd != 0) $fclose(fd);
		report_and_finish();
	end

endmodule

`default_nettype wire

// File: testbench/mem_subsystem_assertions.sv
`default_nettype none
`timescale 1ns/1ps

module mem_subsystem_assertions (
	input wire clk,
	input wire rst_n,
	input wire reserve,
	input wire sb_full,
	input wire load_req,
	input wire drain_pop,
	input wire load_done
);

	// Dispatch never claims a slot when the buffer is full
	no_reserve_when_full: assert property (@(posedge clk) disable iff (!rst_n)
		reserve |-> !sb_full)
		else $error("Reserve while the store buffer is full");

	// Read and drain write share one cache port
	one_port_access: assert property (@(posedge clk) disable iff (!rst_n)
		!(load_req && drain_pop))
		else $error("Read and write on the cache port in the same cycle");

	load_done_next_cycle: assert property (@(posedge clk) disable iff (!rst_n)
		load_req |=> load_done)
		else $error("No load result one cycle after a load issue");

	load_done_needs_issue: assert property (@(posedge clk) disable iff (!rst_n)
		load_done |-> $past(load_req))
		else $error("Load result without a load issued in the previous cycle");

endmodule

bind mem_subsystem mem_subsystem_assertions u_assertions (
	.clk(clk), .rst_n(rst_n), .reserve(reserve), .sb_full(sb_full),
	.load_req(load_req), .drain_pop(drain_pop), .load_done(load_done)
);

`default_nettype wire

// File: hw/mem_subsystem.sv
`default_nettype none
`timescale 1ns/1ps

module mem_subsystem (
	input  wire clk,
	input  wire rst_n,
	// Dispatch side
	input  wire reserve,
	output wire mem_subsystem_pkg::sb_idx_t reserve_index,
	output wire sb_full,
	output wire sb_empty,
	// Issue
	input  wire issue_valid,
	input  wire mem_subsystem_pkg::ls_issue_t issue,
	// Retire side
	input  wire retire_valid,
	input  wire mem_subsystem_pkg::sb_idx_t retire_index,
	input  wire flush,
	// Load result
	output wire load_done,
	output wire mem_subsystem_pkg::data_t load_data
);
	import mem_subsystem_pkg::*;

	// LSU to store buffer
	logic sb_fill_valid;
	sb_fill_t sb_fill;
	addr_t search_addr;
	sb_search_t sb_search;

	// LSU to cache port
	logic load_req;
	addr_t load_addr;
	data_t mem_rdata;

	// Store buffer head to cache port
	logic drain_req;
	addr_t drain_addr;
	data_t drain_data;
	logic drain_pop;

	load_store_unit u_lsu (
		.clk(clk), .rst_n(rst_n),
		.issue_valid(issue_valid), .issue(issue),
		.sb_fill_valid(sb_fill_valid), .sb_fill(sb_fill),
		.search_addr(search_addr), .sb_search(sb_search),
		.load_req(load_req), .load_addr(load_addr), .mem_rdata(mem_rdata),
		.load_done(load_done), .load_data(load_data)
	);

	store_buffer u_sb (
		.clk(clk), .rst_n(rst_n),
		.reserve(reserve), .reserve_index(reserve_index),
		.sb_full(sb_full), .sb_empty(sb_empty),
		.sb_fill_valid(sb_fill_valid), .sb_fill(sb_fill),
		.search_addr(search_addr), .sb_search(sb_search),
		.retire_valid(retire_valid), .retire_index(retire_index), .flush(flush),
		.drain_req(drain_req), .drain_addr(drain_addr), .drain_data(drain_data),
		.drain_pop(drain_pop)
	);

	data_memory u_dmem (
		.clk(clk),
		.load_req(load_req), .load_addr(load_addr),
		.drain_req(drain_req), .drain_addr(drain_addr), .drain_data(drain_data),
		.drain_pop(drain_pop), .mem_rdata(mem_rdata)
	);

endmodule

`default_nettype wire

// File: hw/data_memory.sv
`default_nettype none
`timescale 1ns/1ps

`include "mem_subsystem_config.svh"

module data_memory (
	input  wire clk,
	// Load read from the LSU
	input  wire load_req,
	input  wire mem_subsystem_pkg::addr_t load_addr,
	// Committed head store
	input  wire drain_req,
	input  wire mem_subsystem_pkg::addr_t drain_addr,
	input  wire mem_subsystem_pkg::data_t drain_data,
	output logic drain_pop,
	output mem_subsystem_pkg::data_t mem_rdata
);
	import mem_subsystem_pkg::*;

	localparam int MEM_WORDS = 1 << `MEM_ADDR_BITS;

	mem_req_t port_req;
	logic [`MEM_ADDR_BITS-1:0] word_idx;
	data_t mem [MEM_WORDS];

	// ------------------------------
	// Port arbitration, reads first
	always_comb begin
		port_req = '0;
		if (load_req) begin
			port_req.read = 1'b1;
			port_req.addr = load_addr;
		end else if (drain_req) begin
			port_req.write = 1'b1;
			port_req.addr = drain_addr;
			port_req.data = drain_data;
		end
	end

	assign drain_pop = port_req.write;  // Head leaves the buffer on this edge
	assign word_idx = port_req.addr[`MEM_ADDR_BITS-1:0];

	// ------------------------------
	// Word memory
	initial begin
		for (int i = 0; i < MEM_WORDS; i++) begin
			mem[i] = '0;
		end
	end

	always_ff @(posedge clk) begin
		if (port_req.write) begin
			mem[word_idx] <= port_req.data;
		end
		if (port_req.read) begin
			mem_rdata <= mem[word_idx];  // Registered read
		end
	end

endmodule

`default_nettype wire

// File: hw/store_buffer.sv
`default_nettype none
`timescale 1ns/1ps

`include "mem_subsystem_config.svh"

module store_buffer (
	input  wire clk,
	input  wire rst_n,
	// Dispatch
	input  wire reserve,
	output mem_subsystem_pkg::sb_idx_t reserve_index,
	output logic sb_full,
	output logic sb_empty,
	// Execute
	input  wire sb_fill_valid,
	input  wire mem_subsystem_pkg::sb_fill_t sb_fill,
	input  wire mem_subsystem_pkg::addr_t search_addr,
	output mem_subsystem_pkg::sb_search_t sb_search,
	// Retire and flush
	input  wire retire_valid,
	input  wire mem_subsystem_pkg::sb_idx_t retire_index,
	input  wire flush,
	// Head drain to the cache
	output logic drain_req,
	output mem_subsystem_pkg::addr_t drain_addr,
	output mem_subsystem_pkg::data_t drain_data,
	input  wire drain_pop
);
	import mem_subsystem_pkg::*;

	// Per-slot state
	logic [`SB_DEPTH-1:0] valid_q;      // Reserved and not yet drained
	logic [`SB_DEPTH-1:0] filled_q;     // Store has executed
	logic [`SB_DEPTH-1:0] committed_q;  // Store has retired
	addr_t addr_q [`SB_DEPTH];
	data_t data_q [`SB_DEPTH];

	sb_idx_t head_q;    // Oldest slot
	sb_idx_t tail_q;    // Next slot to reserve
	sb_idx_t commit_q;  // One past the last committed slot
	sb_idx_t commit_next;

	// Valid slots are always the contiguous run head..tail-1
	assign reserve_index = tail_q;
	assign sb_full = valid_q[tail_q];
	assign sb_empty = ~valid_q[head_q];

	// A retire in the flush cycle still counts as committed
	assign commit_next = retire_valid ? retire_index + 1'b1 : commit_q;

	// ------------------------------
	// Slot control
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			valid_q <= '0;
			filled_q <= '0;
			committed_q <= '0;
			head_q <= '0;
			tail_q <= '0;
			commit_q <= '0;
		end else begin
			if (reserve && !flush) begin
				valid_q[tail_q] <= 1'b1;
				filled_q[tail_q] <= 1'b0;
				committed_q[tail_q] <= 1'b0;
				tail_q <= tail_q + 1'b1;
			end

			if (sb_fill_valid) begin
				filled_q[sb_fill.index] <= 1'b1;
			end

			if (retire_valid) begin
				committed_q[retire_index] <= 1'b1;
			end
			commit_q <= commit_next;

			if (drain_pop) begin
				valid_q[head_q] <= 1'b0;
				filled_q[head_q] <= 1'b0;
				committed_q[head_q] <= 1'b0;
				head_q <= head_q + 1'b1;
			end

			// Squash speculative slots, they are always the newest
			if (flush) begin
				for (int i = 0; i < `SB_DEPTH; i++) begin
					if (!committed_q[i] && !(retire_valid && retire_index == sb_idx_t'(i))) begin
						valid_q[i] <= 1'b0;
					end
				end
				tail_q <= commit_next;
			end
		end
	end

	// Payload written by the executed store
	always_ff @(posedge clk) begin
		if (sb_fill_valid) begin
			addr_q[sb_fill.index] <= sb_fill.addr;
			data_q[sb_fill.index] <= sb_fill.data;
		end
	end

	// ------------------------------
	// Forwarding search
	// Walk in allocation order so the newest match is kept
	always_comb begin
		sb_idx_t idx;
		sb_search = '0;
		for (int k = 0; k < `SB_DEPTH; k++) begin
			idx = head_q + sb_idx_t'(k);
			if (valid_q[idx] && filled_q[idx] && addr_q[idx] == search_addr) begin
				sb_search.match = 1'b1;
				sb_search.data = data_q[idx];
			end
		end
	end

	// ------------------------------
	// Head drain
	assign drain_req = valid_q[head_q] & filled_q[head_q] & committed_q[head_q];
	assign drain_addr = addr_q[head_q];
	assign drain_data = data_q[head_q];

endmodule

`default_nettype wire

// File: hw/load_store_unit.sv
`default_nettype none
`timescale 1ns/1ps

module load_store_unit (
	input  wire clk,
	input  wire rst_n,
	// From issue
	input  wire issue_valid,
	input  wire mem_subsystem_pkg::ls_issue_t issue,
	// Store buffer side
	output logic sb_fill_valid,
	output mem_subsystem_pkg::sb_fill_t sb_fill,
	output mem_subsystem_pkg::addr_t search_addr,
	input  wire mem_subsystem_pkg::sb_search_t sb_search,
	// Cache port
	output logic load_req,
	output mem_subsystem_pkg::addr_t load_addr,
	input  wire mem_subsystem_pkg::data_t mem_rdata,
	// Load result
	output logic load_done,
	output mem_subsystem_pkg::data_t load_data
);
	import mem_subsystem_pkg::*;

	addr_t eff_addr;
	logic is_load;
	logic load_pending_q;  // Load issued last cycle
	sb_search_t fwd_q;     // Forward result captured at issue

	// ------------------------------
	// Address generation and routing
	assign eff_addr = issue.base + issue.offset;
	assign is_load = issue_valid & ~issue.is_store;

	assign sb_fill_valid = issue_valid & issue.is_store;
	assign sb_fill = '{index: issue.sb_index, addr: eff_addr, data: issue.src_data};

	// Loads probe the buffer and read memory in parallel
	assign search_addr = eff_addr;
	assign load_req = is_load;
	assign load_addr = eff_addr;

	// ------------------------------
	// One-cycle load return
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			load_pending_q <= 1'b0;
		end else begin
			load_pending_q <= is_load;
		end
	end

	always_ff @(posedge clk) begin
		fwd_q <= sb_search;
	end

	assign load_done = load_pending_q;
	assign load_data = fwd_q.match ? fwd_q.data : mem_rdata;  // Buffer wins over memory

endmodule

`default_nettype wire

// File: hw/mem_subsystem_pkg.sv
`default_nettype none

`include "mem_subsystem_config.svh"

package mem_subsystem_pkg;

	// ------------------------------
	// Basic vectors
	typedef logic [`ADDR_W-1:0]   addr_t;    // word address
	typedef logic [`DATA_W-1:0]   data_t;
	typedef logic [`SB_IDX_W-1:0] sb_idx_t;  // store buffer slot

	// ------------------------------
	// Memory operation from issue
	typedef struct packed {
		logic    is_store;   // 0 means load
		addr_t   base;
		addr_t   offset;
		data_t   src_data;   // Store data only
		sb_idx_t sb_index;   // Slot reserved at dispatch
	} ls_issue_t;

	// Executed store into its slot
	typedef struct packed {
		sb_idx_t index;
		addr_t   addr;
		data_t   data;
	} sb_fill_t;

	// Forwarding answer for a load
	typedef struct packed {
		logic  match;
		data_t data;
	} sb_search_t;

	// Cache port request, at most one of read/write
	typedef struct packed {
		logic  read;
		logic  write;
		addr_t addr;
		data_t data;
	} mem_req_t;

endpackage

`default_nettype wire

// File: hw/mem_subsystem_config.svh
`ifndef MEM_SUBSYSTEM_CONFIG_SVH
`define MEM_SUBSYSTEM_CONFIG_SVH

// Store buffer geometry
`define SB_DEPTH 32
`define SB_IDX_W 5  // log2 of SB_DEPTH

// Datapath widths
`define DATA_W 16
`define ADDR_W 16

// Low address bits decoded by the data memory
`define MEM_ADDR_BITS 8

`endif
